// File: verilog.f
design/chiplet_pkg.sv
design/flit_fifo.sv
design/flit_endpoint.sv
design/flit_serializer.sv
design/flit_deserializer.sv
design/chiplet_link_top.sv
testbench/tb_chiplet_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the loopback testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 \
    --top-module tb_chiplet_link \
    -f verilog.f \
    -o tb_chiplet_link > sim.log 2>&1 \
    && ./obj_dir/tb_chiplet_link >> sim.log 2>&1

grep -q "Test OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: testbench/tb_chiplet_link.sv
module tb_chiplet_link;

    localparam int FLIT_LAT = 4 * 10 * chiplet_pkg::CLKS_PER_BIT + 4;  // one flit on an idle line
    localparam int MAX_CYCLES = 20000;              // ~40 flit times of traffic plus margin
    localparam int NUM_PKTS = 5;

    // {dest, vc, length, error expected}
    localparam logic [8:0] STIM_TBL [NUM_PKTS] = '{
        {4'd3,  1'b0, 3'd1, 1'b0},
        {4'd9,  1'b1, 3'd2, 1'b0},
        {4'd12, 1'b0, 3'd3, 1'b1},                  // second header inside the packet
        {4'd1,  1'b1, 3'd0, 1'b0},                  // length 0 sends one payload
        {4'd15, 1'b0, 3'd3, 1'b0}
    };

    logic CLOCK_50;
    logic KEY;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [1:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic wb_ack;
    logic serial_line;                              // tx looped back to rx

    int cycles;
    int ack_wait;
    int max_ack_wait;
    logic [31:0] exp_q [$];

    chiplet_link_top u_chiplet_link_top (
        .CLOCK_50  (CLOCK_50),
        .KEY       (KEY),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .serial_tx (serial_line),
        .serial_rx (serial_line)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        $display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
        $display("Test FAILED");
        $fatal(1, "simulation timed out");
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] make_head(input logic [3:0] dest, input logic vc,
                                              input logic [2:0] len);
        return {2'd1, dest, vc, len, 4'd5, 18'd0};  // head type from node 5
    endfunction

    function automatic logic [31:0] make_data(input logic last, input logic [31:0] word);
        return {(last ? 2'd3 : 2'd2), word[29:0]};  // tail or body
    endfunction

    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        @(posedge CLOCK_50);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = data;
        ack_wait = 0;
        @(posedge CLOCK_50);
        #2;
        while (!wb_ack) begin
            ack_wait++;                             // extra cycles past the usual one
            @(posedge CLOCK_50);
            #2;
        end
        rdata = wb_dat_r;
        @(posedge CLOCK_50);                        // master samples ack here
        #2;
        check_value(32'(wb_ack), 32'd0, "ack is a single-cycle pulse");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        if (ack_wait > max_ack_wait) begin
            max_ack_wait = ack_wait;
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'd0, data);
        check_value(32'(ack_wait), 32'd0, "read acknowledged in the next cycle");
    endtask

    function automatic logic [31:0] rx_count_of(input logic [31:0] st);
        return 32'(st[chiplet_pkg::ST_RX_COUNT +: chiplet_pkg::FIFO_AW]);
    endfunction

    task automatic send_packet(input logic [3:0] dest, input logic vc, input logic [2:0] len,
                               input logic extra_hdr, output int n_flits);
        logic [31:0] word;
        logic [31:0] st;
        int n_pay;
        n_pay = (len == 3'd0) ? 1 : int'(len);
        n_flits = n_pay + 1;
        word = $urandom;                            // junk in type, src and reserved
        word[29:22] = {dest, vc, len};
        wb_write(chiplet_pkg::ADR_HEADER, word);
        exp_q.push_back(make_head(dest, vc, len));
        if (extra_hdr) begin
            wb_write(chiplet_pkg::ADR_HEADER, word ^ 32'h0400_0000);
            wb_read(chiplet_pkg::ADR_STATUS, st);
            check_value(32'(st[chiplet_pkg::ST_ERROR]), 32'd1, "error on header in packet");
            check_value(32'(st[chiplet_pkg::ST_PKT_OPEN]), 32'd1, "packet still open");
        end
        for (int k = 0; k < n_pay; k++) begin
            word = $urandom;
            wb_write(chiplet_pkg::ADR_PAYLOAD, word);
            exp_q.push_back(make_data(k == n_pay - 1, word));
        end
    endtask

    task automatic wait_rx_count(input int target, output logic [31:0] st);
        do begin
            wb_read(chiplet_pkg::ADR_STATUS, st);
            check_value(32'(st[chiplet_pkg::ST_ERROR]), 32'd0, "no error while flits arrive");
        end while (int'(rx_count_of(st)) < target);
    endtask

    task automatic read_flits(input int n);
        logic [31:0] word;
        for (int k = 0; k < n; k++) begin
            wb_read(chiplet_pkg::ADR_RX_FLIT, word);
            check_value(word, exp_q.pop_front(), "received flit");
        end
    endtask

    task automatic stream_flits(input int n);
        logic [31:0] st;
        for (int k = 0; k < n; k++) begin
            wait_rx_count(1, st);
            read_flits(1);
        end
    endtask

    initial begin
        logic [31:0] st;
        logic [31:0] word;
        int n_flits;
        int n_more;
        void'($urandom(1082));
        KEY = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 2'd0;
        wb_dat_w = 32'd0;
        max_ack_wait = 0;
        repeat (4) @(posedge CLOCK_50);
        #2;
        KEY = 1'b1;

        check_value(32'(serial_line), 32'd1, "serial_tx idle after reset");
        check_value(32'(wb_ack), 32'd0, "wb_ack after reset");
        wb_read(chiplet_pkg::ADR_STATUS, st);
        check_value(st, 32'd0, "status after reset");
        wb_read(chiplet_pkg::ADR_RX_FLIT, word);
        check_value(word, 32'd0, "empty rx read");

        // payload with no packet open
        wb_write(chiplet_pkg::ADR_PAYLOAD, $urandom);
        wb_read(chiplet_pkg::ADR_STATUS, st);
        check_value(32'(st[chiplet_pkg::ST_ERROR]), 32'd1, "error on stray payload");
        wb_read(chiplet_pkg::ADR_STATUS, st);
        check_value(32'(st[chiplet_pkg::ST_ERROR]), 32'd0, "error cleared by status read");
        repeat (FLIT_LAT) @(posedge CLOCK_50);
        wb_read(chiplet_pkg::ADR_STATUS, st);
        check_value(rx_count_of(st), 32'd0, "nothing sent for stray payload");

        for (int i = 0; i < NUM_PKTS; i++) begin
            send_packet(STIM_TBL[i][8:5], STIM_TBL[i][4], STIM_TBL[i][3:1], STIM_TBL[i][0],
                        n_flits);
            wait_rx_count(n_flits, st);
            check_value(rx_count_of(st), 32'(n_flits), "rx count after packet");
            check_value(32'(st[chiplet_pkg::ST_PKT_OPEN]), 32'd0, "packet closed by tail");
            read_flits(n_flits);
        end

        // two packets back to back overfill the tx queue
        max_ack_wait = 0;
        send_packet(4'd10, 1'b1, 3'd4, 1'b0, n_flits);
        send_packet(4'd6, 1'b0, 3'd1, 1'b0, n_more);
        check_value(32'(max_ack_wait > 10 * chiplet_pkg::CLKS_PER_BIT), 32'd1,
                    "write held off while tx queue full");
        stream_flits(n_flits + n_more);

        // nothing read back so the rx queue overflows
        send_packet(4'd2, 1'b0, 3'd4, 1'b0, n_flits);
        send_packet(4'd7, 1'b1, 3'd4, 1'b0, n_more);
        repeat ((chiplet_pkg::FIFO_DEPTH + 2) * FLIT_LAT) @(posedge CLOCK_50);  // last flits land
        wb_read(chiplet_pkg::ADR_STATUS, st);
        check_value(32'(st[chiplet_pkg::ST_ERROR]), 32'd1, "error on rx overrun");
        check_value(rx_count_of(st), 32'(chiplet_pkg::FIFO_DEPTH), "rx count on overrun");
        read_flits(chiplet_pkg::FIFO_DEPTH);
        exp_q.delete();
        wb_read(chiplet_pkg::ADR_STATUS, st);
        check_value(st, 32'd0, "status after draining");
        wb_read(chiplet_pkg::ADR_RX_FLIT, word);
        check_value(word, 32'd0, "empty rx read after draining");

        $display("Test OK");
        $finish;
    end

endmodule

// File: design/chiplet_link_top.sv
module chiplet_link_top (
    input  logic        CLOCK_50,
    input  logic        KEY,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        serial_tx,
    input  logic        serial_rx
);

    logic tx_push;
    logic tx_pop;
    logic tx_full;
    logic tx_empty;
    chiplet_pkg::flit_t tx_flit;
    chiplet_pkg::flit_t tx_head;

    logic rx_push;
    logic rx_pop;
    logic rx_full;
    logic rx_empty;
    logic rx_overrun;
    logic [chiplet_pkg::FIFO_AW-1:0] rx_count;
    chiplet_pkg::flit_t rx_flit;
    chiplet_pkg::flit_t rx_head;

    flit_endpoint u_endpoint (
        .CLOCK_50   (CLOCK_50),
        .KEY        (KEY),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .tx_push    (tx_push),
        .tx_flit    (tx_flit),
        .tx_full    (tx_full),
        .rx_pop     (rx_pop),
        .rx_head    (rx_head),
        .rx_empty   (rx_empty),
        .rx_count   (rx_count),
        .rx_overrun (rx_overrun)
    );

    flit_fifo u_tx_fifo (
        .CLOCK_50 (CLOCK_50),
        .KEY      (KEY),
        .push     (tx_push),
        .din      (tx_flit),
        .pop      (tx_pop),
        .head     (tx_head),
        .empty    (tx_empty),
        .full     (tx_full),
        .count    ()                                // tx occupancy not reported
    );

    flit_serializer u_serializer (
        .CLOCK_50   (CLOCK_50),
        .KEY        (KEY),
        .flit_empty (tx_empty),
        .flit_head  (tx_head),
        .flit_pop   (tx_pop),
        .serial_tx  (serial_tx)
    );

    flit_deserializer u_deserializer (
        .CLOCK_50  (CLOCK_50),
        .KEY       (KEY),
        .serial_rx (serial_rx),
        .flit_push (rx_push),
        .flit_out  (rx_flit),
        .fifo_full (rx_full),
        .overrun   (rx_overrun)
    );

    flit_fifo u_rx_fifo (
        .CLOCK_50 (CLOCK_50),
        .KEY      (KEY),
        .push     (rx_push),
        .din      (rx_flit),
        .pop      (rx_pop),
        .head     (rx_head),
        .empty    (rx_empty),
        .full     (rx_full),
        .count    (rx_count)
    );

endmodule

// File: design/flit_deserializer.sv
module flit_deserializer (
    input  logic                CLOCK_50,
    input  logic                KEY,
    input  logic                serial_rx,
    output logic                flit_push,
    output chiplet_pkg::flit_t  flit_out,
    input  logic                fifo_full,
    output logic                overrun
);

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic active;
    logic sample;
    logic [chiplet_pkg::BIT_CNT_W-1:0] clk_cnt;
    logic [3:0] bit_idx;
    logic [1:0] byte_cnt;                           // good bytes so far
    logic [7:0] byte_q;

    assign sample = active && (clk_cnt == chiplet_pkg::BIT_MID);

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
            active <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            byte_cnt <= '0;
            flit_push <= 1'b0;
            overrun <= 1'b0;
        end else begin
            rx_meta <= serial_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            flit_push <= 1'b0;
            overrun <= 1'b0;
            if (!active) begin
                if (rx_prev && !rx_sync) begin
                    active <= 1'b1;                 // start edge
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else begin
                if (clk_cnt == chiplet_pkg::BIT_LAST) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 4'd1;
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                if (sample && bit_idx == 4'd0 && rx_sync) begin
                    active <= 1'b0;                 // glitch, not a start bit
                end
                if (sample && bit_idx == 4'd9) begin
                    active <= 1'b0;
                    if (!rx_sync) begin
                        byte_cnt <= '0;             // framing error, drop flit
                    end else begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            flit_push <= !fifo_full;
                            overrun <= fifo_full;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            byte_q <= {rx_sync, byte_q[7:1]};       // lsb arrives first
        end
        if (sample && bit_idx == 4'd9 && rx_sync) begin
            flit_out <= {flit_out[23:0], byte_q};
        end
    end

endmodule

// File: design/flit_serializer.sv
module flit_serializer (
    input  logic                CLOCK_50,
    input  logic                KEY,
    input  logic                flit_empty,
    input  chiplet_pkg::flit_t  flit_head,
    output logic                flit_pop,
    output logic                serial_tx
);

    logic busy;
    logic [chiplet_pkg::BIT_CNT_W-1:0] clk_cnt;
    logic [3:0] bit_idx;                            // 0 start, 1..8 data, 9 stop
    logic [1:0] byte_idx;
    logic [31:0] shreg;
    logic [7:0] cur_byte;
    logic tx_bit;

    assign flit_pop = !busy && !flit_empty;
    assign cur_byte = shreg[31:24];                 // msb byte leads

    always_comb begin
        if (!busy) begin
            tx_bit = 1'b1;
        end else if (bit_idx == 4'd0) begin
            tx_bit = 1'b0;
        end else if (bit_idx == 4'd9) begin
            tx_bit = 1'b1;
        end else begin
            tx_bit = cur_byte[bit_idx[2:0] - 3'd1];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            byte_idx <= '0;
            serial_tx <= 1'b1;
        end else begin
            serial_tx <= tx_bit;
            if (!busy) begin
                if (flit_pop) begin
                    busy <= 1'b1;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    byte_idx <= '0;
                end
            end else if (clk_cnt == chiplet_pkg::BIT_LAST) begin
                clk_cnt <= '0;
                if (bit_idx == 4'd9) begin
                    bit_idx <= '0;
                    byte_idx <= byte_idx + 2'd1;
                    if (byte_idx == 2'd3) begin
                        busy <= 1'b0;               // all four bytes sent
                    end
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (flit_pop) begin
            shreg <= flit_head;
        end else if (busy && clk_cnt == chiplet_pkg::BIT_LAST && bit_idx == 4'd9) begin
            shreg <= {shreg[23:0], 8'h00};
        end
    end

endmodule

// File: design/flit_endpoint.sv
module flit_endpoint (
    input  logic                             CLOCK_50,
    input  logic                             KEY,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [1:0]                       wb_adr,
    input  logic [31:0]                      wb_dat_w,
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack,
    output logic                             tx_push,
    output chiplet_pkg::flit_t               tx_flit,
    input  logic                             tx_full,
    output logic                             rx_pop,
    input  chiplet_pkg::flit_t               rx_head,
    input  logic                             rx_empty,
    input  logic [chiplet_pkg::FIFO_AW-1:0]  rx_count,
    input  logic                             rx_overrun
);

    logic is_tx_wr;
    logic stall;
    logic accept;
    logic pkt_open;
    logic error;
    logic [2:0] remain;                             // payload flits still owed
    logic [2:0] hdr_len;
    chiplet_pkg::flit_t wr_word;
    chiplet_pkg::flit_t head_flit;
    chiplet_pkg::flit_t data_flit;
    logic [31:0] status;
    logic [31:0] rd_data;

    assign wr_word = wb_dat_w;
    assign is_tx_wr = wb_we &&
        (wb_adr == chiplet_pkg::ADR_HEADER || wb_adr == chiplet_pkg::ADR_PAYLOAD);
    assign stall = is_tx_wr && tx_full;             // hold ack off until room
    assign accept = wb_cyc && wb_stb && !wb_ack && !stall;
    assign hdr_len = (wr_word.hdr.length == 3'd0) ? 3'd1 : wr_word.hdr.length;

    always_comb begin
        head_flit = '0;
        head_flit.hdr.flit_type = chiplet_pkg::FLIT_HEAD;
        head_flit.hdr.dest_id = wr_word.hdr.dest_id;
        head_flit.hdr.vc = wr_word.hdr.vc;
        head_flit.hdr.length = wr_word.hdr.length;
        head_flit.hdr.src_id = chiplet_pkg::NODE_ID;

        data_flit = '0;
        data_flit.dat.flit_type = (remain == 3'd1) ? chiplet_pkg::FLIT_TAIL
                                                   : chiplet_pkg::FLIT_BODY;
        data_flit.dat.payload = wb_dat_w[29:0];
    end

    always_comb begin
        status = '0;
        status[chiplet_pkg::ST_TX_FULL] = tx_full;
        status[chiplet_pkg::ST_RX_COUNT +: chiplet_pkg::FIFO_AW] = rx_count;
        status[chiplet_pkg::ST_PKT_OPEN] = pkt_open;
        status[chiplet_pkg::ST_ERROR] = error;
    end

    always_comb begin
        case (wb_adr)
            chiplet_pkg::ADR_RX_FLIT: rd_data = rx_empty ? '0 : rx_head;
            chiplet_pkg::ADR_STATUS:  rd_data = status;
            default:                  rd_data = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            wb_ack <= 1'b0;
            tx_push <= 1'b0;
            rx_pop <= 1'b0;
            pkt_open <= 1'b0;
            remain <= '0;
            error <= 1'b0;
        end else begin
            wb_ack <= accept;
            tx_push <= 1'b0;
            rx_pop <= 1'b0;
            if (accept && wb_we) begin
                case (wb_adr)
                    chiplet_pkg::ADR_HEADER: begin
                        if (pkt_open) begin
                            error <= 1'b1;          // header inside a packet
                        end else begin
                            tx_push <= 1'b1;
                            pkt_open <= 1'b1;
                            remain <= hdr_len;
                        end
                    end
                    chiplet_pkg::ADR_PAYLOAD: begin
                        if (!pkt_open) begin
                            error <= 1'b1;          // payload without header
                        end else begin
                            tx_push <= 1'b1;
                            remain <= remain - 3'd1;
                            if (remain == 3'd1) begin
                                pkt_open <= 1'b0;   // tail goes out
                            end
                        end
                    end
                    default: ;                      // read-only registers
                endcase
            end
            if (accept && !wb_we) begin
                if (wb_adr == chiplet_pkg::ADR_RX_FLIT) begin
                    rx_pop <= !rx_empty;
                end
                if (wb_adr == chiplet_pkg::ADR_STATUS) begin
                    error <= 1'b0;                  // cleared once reported
                end
            end
            if (rx_overrun) begin
                error <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (accept && wb_we) begin
            tx_flit <= (wb_adr == chiplet_pkg::ADR_HEADER) ? head_flit : data_flit;
        end
        if (accept && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// File: design/flit_fifo.sv
module flit_fifo (
    input  logic                             CLOCK_50,
    input  logic                             KEY,
    input  logic                             push,
    input  chiplet_pkg::flit_t               din,
    input  logic                             pop,
    output chiplet_pkg::flit_t               head,
    output logic                             empty,
    output logic                             full,
    output logic [chiplet_pkg::FIFO_AW-1:0]  count
);

    chiplet_pkg::flit_t mem [chiplet_pkg::FIFO_DEPTH];

    logic [chiplet_pkg::FIFO_PW-1:0] wr_ptr;
    logic [chiplet_pkg::FIFO_PW-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full = (count == chiplet_pkg::FIFO_FULL_CNT);
    assign head = mem[rd_ptr];                      // fall-through read
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;            // depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;                          // none, or both at once
            endcase
        end
    end

endmodule

// File: design/chiplet_pkg.sv
package chiplet_pkg;

    localparam logic [1:0] FLIT_HEAD = 2'd1;
    localparam logic [1:0] FLIT_BODY = 2'd2;
    localparam logic [1:0] FLIT_TAIL = 2'd3;

    localparam logic [3:0] NODE_ID = 4'd5;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW = 3;                     // holds 0..FIFO_DEPTH
    localparam int FIFO_PW = $clog2(FIFO_DEPTH);
    localparam logic [FIFO_AW-1:0] FIFO_FULL_CNT = FIFO_AW'(FIFO_DEPTH);

    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
    // one less than half, the edge detect already costs a cycle
    localparam logic [BIT_CNT_W-1:0] BIT_MID = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

    localparam logic [1:0] ADR_HEADER  = 2'd0;
    localparam logic [1:0] ADR_PAYLOAD = 2'd1;
    localparam logic [1:0] ADR_RX_FLIT = 2'd2;
    localparam logic [1:0] ADR_STATUS  = 2'd3;

    localparam int ST_TX_FULL  = 0;
    localparam int ST_RX_COUNT = 1;                 // 3 bits wide
    localparam int ST_PKT_OPEN = 4;
    localparam int ST_ERROR    = 5;

    typedef union packed {
        struct packed {
            logic [1:0]  flit_type;
            logic [3:0]  dest_id;
            logic        vc;
            logic [2:0]  length;                    // payload flits, 1..4
            logic [3:0]  src_id;
            logic [17:0] rsvd;
        } hdr;
        struct packed {
            logic [1:0]  flit_type;
            logic [29:0] payload;
        } dat;
    } flit_t;

endpackage
